// File: common/hss_link_consts.svh
// Link-control constants for the serial multiplexer
// K-character codes, protocol version and idle frame K-flags
// Clock-correction interval, sync timeout and LFSR seed

`ifndef HSS_LINK_CONSTS_SVH
`define HSS_LINK_CONSTS_SVH

// K-characters, one per word position
// K28.5 comma opens every handshake frame
`define KCH_COMMA        8'hBC
`define KCH_HANDSHAKE    8'h3C
`define KCH_CLKC         8'h1C
`define KCH_IDLE         8'h7C

// Version byte carried in the low byte of a handshake frame
`define PROTOCOL_VERSION 8'h01

// Idle frame has a K character in the top byte only
`define IDLE_KBITS       4'b1000
`define IDLE_BITS        16

// Clock-correction period in cycles minus one
`define CLKC_INTERVAL    63

// Consecutive words without a sync frame before sync is declared lost
`define SYNC_TIMEOUT     16

// Reset state of the idle payload LFSR
`define LFSR_SEED        16'hACE1

`endif

// File: common/hss_link_pkg.sv
// Shared types of the link-control layer
// Link word struct, handshake states and receive frame kinds

package hss_link_pkg;

  // One word on the serial or user side
  // Bit n of charisk flags byte n of data as a K character
  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  charisk;
  } link_word_t;

  // Handshake progress
  // Phase 0 waits for any compatible peer, phase 1 for a peer in phase 1
  typedef enum logic [1:0] {
    HS_PHASE0   = 2'd0,
    HS_PHASE1   = 2'd1,
    HS_COMPLETE = 2'd2
  } hs_state_e;

  // Receive classifier result
  typedef enum logic [2:0] {
    FK_DATA      = 3'd0,
    FK_IDLE      = 3'd1,
    FK_CLKC      = 3'd2,
    FK_HANDSHAKE = 3'd3,
    FK_OTHER     = 3'd4
  } frame_kind_e;

endpackage

// File: logic/hss_lfsr.sv
// Pseudo-random source for idle frame payloads
// 16-bit Fibonacci LFSR, taps 16 14 13 11, stepped on demand

`timescale 1ns/1ps

`include "hss_link_consts.svh"

module hss_lfsr (
  input  logic                   CLK_IN,
  input  logic                   RESET_IN,
  input  logic                   next_i,
  output logic [`IDLE_BITS-1:0]  value_o
);

  logic [`IDLE_BITS-1:0] lfsr_q;
  logic                  feedback;

  // Taps 16, 14, 13 and 11 counted from one
  assign feedback = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];

  // Step only when the current value is sent
  always_ff @(posedge CLK_IN or posedge RESET_IN)
  begin
    if (RESET_IN)
      lfsr_q <= `LFSR_SEED;
    else if (next_i)
      lfsr_q <= {lfsr_q[14:0], feedback};
  end

  assign value_o = lfsr_q;

endmodule

// File: logic/hss_clkc_timer.sv
// Clock-correction pacing timer
// Wrapping counter with a count-zero strobe

`timescale 1ns/1ps

`include "hss_link_consts.svh"

module hss_clkc_timer (
  input  logic CLK_IN,
  input  logic RESET_IN,
  output logic due_o
);

  localparam int CNT_W = $clog2(`CLKC_INTERVAL + 1);

  logic [CNT_W-1:0] cnt_q;

  // Runs 0 .. CLKC_INTERVAL then wraps
  always_ff @(posedge CLK_IN or posedge RESET_IN)
  begin
    if (RESET_IN)
      cnt_q <= '0;
    else if (cnt_q == CNT_W'(`CLKC_INTERVAL))
      cnt_q <= '0;
    else
      cnt_q <= cnt_q + 1'b1;
  end

  // One strobe per period
  assign due_o = (cnt_q == '0);

endmodule

// File: logic/hss_handshake_fsm.sv
// Two-phase link handshake FSM
// Phase 0, phase 1 and complete, with restart on loss of sync

`timescale 1ns/1ps

module hss_handshake_fsm
  import hss_link_pkg::*;
(
  input  logic CLK_IN,
  input  logic RESET_IN,
  input  logic hs_seen_i,
  input  logic hs_phase_i,
  input  logic sync_lost_i,
  output logic complete_o,
  output logic phase_o
);

  hs_state_e state_q;
  hs_state_e state_d;

  always_comb
  begin
    state_d = state_q;
    // Loss of sync wins over any handshake seen in the same cycle
    if (sync_lost_i)
      state_d = HS_PHASE0;
    else
    begin
      case (state_q)
        HS_PHASE0:
        begin
          // Peer is alive and speaks our version
          if (hs_seen_i)
            state_d = HS_PHASE1;
        end
        HS_PHASE1:
        begin
          // Peer has also seen us
          if (hs_seen_i && hs_phase_i)
            state_d = HS_COMPLETE;
        end
        HS_COMPLETE:
          state_d = HS_COMPLETE;
        default:
          state_d = HS_PHASE0;
      endcase
    end
  end

  always_ff @(posedge CLK_IN or posedge RESET_IN)
  begin
    if (RESET_IN)
      state_q <= HS_PHASE0;
    else
      state_q <= state_d;
  end

  // Phase bit advertised in outgoing handshake frames
  assign phase_o    = (state_q != HS_PHASE0);
  assign complete_o = (state_q == HS_COMPLETE);

endmodule

// File: hss_tx/hss_tx_control.sv
// Transmit frame selection for the serial link
// Clock-correction, handshake, user word and idle frame priority
// Registered ready toward the user word interface

`timescale 1ns/1ps

`include "hss_link_consts.svh"

module hss_tx_control
  import hss_link_pkg::*;
(
  input  logic                  CLK_IN,
  input  logic                  RESET_IN,
  input  logic                  clkc_due_i,
  input  logic                  hs_complete_i,
  input  logic                  hs_phase_i,
  input  logic [`IDLE_BITS-1:0] idle_value_i,
  input  logic [`IDLE_BITS-1:0] lfsr_value_i,
  output logic                  lfsr_next_o,
  input  link_word_t            tx_word_i,
  input  logic                  tx_vld_i,
  output logic                  tx_rdy_o,
  output link_word_t            link_tx_o
);

  logic                  send_clkc_q;
  logic                  send_hs_q;
  logic                  xfer;
  logic                  idle_sel;
  logic                  use_lfsr;
  logic [`IDLE_BITS-1:0] idle_payload;
  link_word_t            next_word;

  // Requests lag the timer and FSM by one cycle, matching tx_rdy_o
  always_ff @(posedge CLK_IN or posedge RESET_IN)
  begin
    if (RESET_IN)
    begin
      send_clkc_q <= 1'b0;
      // Link starts unconnected so a handshake is pending
      send_hs_q   <= 1'b1;
    end
    else
    begin
      send_clkc_q <= clkc_due_i;
      send_hs_q   <= !hs_complete_i;
    end
  end

  // Accepted user word, never displaced by the higher priorities
  assign xfer     = tx_vld_i && tx_rdy_o;
  assign idle_sel = !send_clkc_q && !send_hs_q && !xfer;

  // Zero idle value selects the pseudo-random pattern
  assign use_lfsr     = (idle_value_i == '0);
  assign idle_payload = use_lfsr ? lfsr_value_i : idle_value_i;
  // Consume an LFSR value only when it goes out
  assign lfsr_next_o  = idle_sel && use_lfsr;

  always_comb
  begin
    if (send_clkc_q)
    begin
      next_word.data    = {4{`KCH_CLKC}};
      next_word.charisk = 4'b1111;
    end
    else if (send_hs_q)
    begin
      // Comma, handshake K, phase byte, version byte
      next_word.data    = {`KCH_COMMA, `KCH_HANDSHAKE, 7'b0, hs_phase_i, `PROTOCOL_VERSION};
      next_word.charisk = 4'b1100;
    end
    else if (xfer)
      next_word = tx_word_i;
    else
    begin
      next_word.data    = {`KCH_IDLE, 8'h00, idle_payload};
      next_word.charisk = `IDLE_KBITS;
    end
  end

  always_ff @(posedge CLK_IN or posedge RESET_IN)
  begin
    if (RESET_IN)
    begin
      link_tx_o <= '0;
      tx_rdy_o  <= 1'b0;
    end
    else
    begin
      link_tx_o <= next_word;
      // Hold off users during a clock-correction slot and before link up
      tx_rdy_o  <= hs_complete_i && !clkc_due_i;
    end
  end

endmodule

// File: hss_rx/hss_rx_control.sv
// Receive frame classification and filtering
// Handshake reporting to the FSM and sync-loss timeout
// Data words delivered without back-pressure

`timescale 1ns/1ps

`include "hss_link_consts.svh"

module hss_rx_control
  import hss_link_pkg::*;
(
  input  logic       CLK_IN,
  input  logic       RESET_IN,
  input  link_word_t link_rx_i,
  output link_word_t rx_word_o,
  output logic       rx_vld_o,
  output logic       hs_seen_o,
  output logic       hs_phase_o,
  output logic       sync_lost_o
);

  localparam int SYNC_W = $clog2(`SYNC_TIMEOUT + 1);

  link_word_t        rx_q;
  logic              rx_live_q;
  frame_kind_e       kind;
  logic              is_sync;
  logic [SYNC_W-1:0] sync_cnt_q;

  // Incoming word register
  always_ff @(posedge CLK_IN)
  begin
    rx_q <= link_rx_i;
  end

  // Marks rx_q as holding a real word after reset
  always_ff @(posedge CLK_IN or posedge RESET_IN)
  begin
    if (RESET_IN)
      rx_live_q <= 1'b0;
    else
      rx_live_q <= 1'b1;
  end

  // Classify by K-flag pattern and the leading K characters
  always_comb
  begin
    if (rx_q.charisk == 4'b0000)
      kind = FK_DATA;
    else if (rx_q.charisk == 4'b1111 && rx_q.data == {4{`KCH_CLKC}})
      kind = FK_CLKC;
    else if (rx_q.charisk == 4'b1100 && rx_q.data[31:16] == {`KCH_COMMA, `KCH_HANDSHAKE})
      kind = FK_HANDSHAKE;
    else if (rx_q.charisk == `IDLE_KBITS && rx_q.data[31:24] == `KCH_IDLE)
      kind = FK_IDLE;
    else
      kind = FK_OTHER;
  end

  // Only plain data reaches the user side
  assign rx_word_o = rx_q;
  assign rx_vld_o  = rx_live_q && (kind == FK_DATA);

  // Handshakes from an incompatible peer are not reported
  assign hs_seen_o  = rx_live_q && (kind == FK_HANDSHAKE)
                      && (rx_q.data[7:0] == `PROTOCOL_VERSION);
  assign hs_phase_o = rx_q.data[8];

  // Frames that prove the link is still framed correctly
  assign is_sync = (kind == FK_IDLE) || (kind == FK_CLKC) || (kind == FK_HANDSHAKE);

  // Fires on the SYNC_TIMEOUT-th consecutive word without sync
  assign sync_lost_o = rx_live_q && !is_sync
                       && (sync_cnt_q == SYNC_W'(`SYNC_TIMEOUT - 1));

  always_ff @(posedge CLK_IN or posedge RESET_IN)
  begin
    if (RESET_IN)
      sync_cnt_q <= '0;
    else if (rx_live_q)
    begin
      if (is_sync || sync_lost_o)
        sync_cnt_q <= '0;
      else
        sync_cnt_q <= sync_cnt_q + 1'b1;
    end
  end

endmodule

// File: logic/hss_link_top.sv
// Link-control layer top level
// Timer, handshake FSM, idle LFSR, transmit and receive control

`timescale 1ns/1ps

`include "hss_link_consts.svh"

module hss_link_top
  import hss_link_pkg::*;
(
  input  logic                  CLK_IN,
  input  logic                  RESET_IN,
  input  link_word_t            tx_word_i,
  input  logic                  tx_vld_i,
  output logic                  tx_rdy_o,
  output link_word_t            link_tx_o,
  input  link_word_t            link_rx_i,
  output link_word_t            rx_word_o,
  output logic                  rx_vld_o,
  input  logic [`IDLE_BITS-1:0] idle_value_i,
  output logic                  link_up_o
);

  logic                  clkc_due;
  logic                  hs_complete;
  logic                  hs_phase;
  logic                  hs_seen;
  logic                  hs_seen_phase;
  logic                  sync_lost;
  logic                  lfsr_next;
  logic [`IDLE_BITS-1:0] lfsr_value;

  hss_lfsr u_lfsr (
    .CLK_IN   (CLK_IN),
    .RESET_IN (RESET_IN),
    .next_i   (lfsr_next),
    .value_o  (lfsr_value)
  );

  hss_clkc_timer u_clkc_timer (
    .CLK_IN   (CLK_IN),
    .RESET_IN (RESET_IN),
    .due_o    (clkc_due)
  );

  // Driven by frames seen on the receive side
  hss_handshake_fsm u_handshake_fsm (
    .CLK_IN      (CLK_IN),
    .RESET_IN    (RESET_IN),
    .hs_seen_i   (hs_seen),
    .hs_phase_i  (hs_seen_phase),
    .sync_lost_i (sync_lost),
    .complete_o  (hs_complete),
    .phase_o     (hs_phase)
  );

  hss_tx_control u_tx_control (
    .CLK_IN        (CLK_IN),
    .RESET_IN      (RESET_IN),
    .clkc_due_i    (clkc_due),
    .hs_complete_i (hs_complete),
    .hs_phase_i    (hs_phase),
    .idle_value_i  (idle_value_i),
    .lfsr_value_i  (lfsr_value),
    .lfsr_next_o   (lfsr_next),
    .tx_word_i     (tx_word_i),
    .tx_vld_i      (tx_vld_i),
    .tx_rdy_o      (tx_rdy_o),
    .link_tx_o     (link_tx_o)
  );

  hss_rx_control u_rx_control (
    .CLK_IN      (CLK_IN),
    .RESET_IN    (RESET_IN),
    .link_rx_i   (link_rx_i),
    .rx_word_o   (rx_word_o),
    .rx_vld_o    (rx_vld_o),
    .hs_seen_o   (hs_seen),
    .hs_phase_o  (hs_seen_phase),
    .sync_lost_o (sync_lost)
  );

  // Link is up only once the handshake has completed
  assign link_up_o = hs_complete;

endmodule

// File: tests/hss_link_tb.sv
// Loopback testbench for the link-control top level
// Reference models for frame kind, idle LFSR and the user word queue
// Output monitor with typed compare tasks and a cycle timeout

`timescale 1ns/1ps

`include "hss_link_consts.svh"

module hss_link_tb
  import hss_link_pkg::*;
();

  localparam int WORDS_PER_BURST = 40;
  // Bring-up, first traffic, resync, second traffic
  localparam int NUM_PHASES      = 4;
  localparam int TIMEOUT_CYCLES  = 20 * (`CLKC_INTERVAL + 1) * NUM_PHASES
                                   + 2 * WORDS_PER_BURST;
  localparam link_word_t ZERO_WORD = '0;

  logic                  CLK_IN;
  logic                  RESET_IN;
  link_word_t            tx_word;
  logic                  tx_vld;
  logic                  tx_rdy;
  link_word_t            link_tx;
  link_word_t            link_rx;
  link_word_t            rx_word;
  logic                  rx_vld;
  logic [`IDLE_BITS-1:0] idle_value;
  logic                  link_up;
  logic                  corrupt;

  // Scoreboard and monitor state
  link_word_t            exp_q[$];
  logic [31:0]           rng_state;
  logic [`IDLE_BITS-1:0] lfsr_model;
  logic [`IDLE_BITS-1:0] idle_sampled;
  logic                  rst_seen;
  logic                  zero_src;
  logic                  prev_rdy;
  logic                  prev_up;
  logic                  hs0_seen;
  logic                  hs1_seen;
  frame_kind_e           tx_kind;
  link_word_t            exp_word;
  int                    mon_cycle;
  int                    last_clkc;
  int                    clkc_count;
  int                    lfsr_idles;
  int                    cycle_cnt;

  hss_link_top u_dut (
    .CLK_IN       (CLK_IN),
    .RESET_IN     (RESET_IN),
    .tx_word_i    (tx_word),
    .tx_vld_i     (tx_vld),
    .tx_rdy_o     (tx_rdy),
    .link_tx_o    (link_tx),
    .link_rx_i    (link_rx),
    .rx_word_o    (rx_word),
    .rx_vld_o     (rx_vld),
    .idle_value_i (idle_value),
    .link_up_o    (link_up)
  );

  // Serial loopback or all-zero data words to break sync
  assign link_rx = corrupt ? ZERO_WORD : link_tx;

  initial
  begin
    CLK_IN = 1'b0;
    forever #5 CLK_IN = ~CLK_IN;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Fibonacci step with taps 16 14 13 11 shifting toward the MSB
  function automatic logic [15:0] lfsr_step(input logic [15:0] v);
    return {v[14:0], v[15] ^ v[13] ^ v[12] ^ v[10]};
  endfunction

  function automatic link_word_t make_word(input logic [31:0] data, input logic [3:0] k);
    link_word_t w;
    w.data    = data;
    w.charisk = k;
    return w;
  endfunction

  // Frame kind from the link frame formats
  function automatic frame_kind_e ref_kind(input link_word_t w);
    frame_kind_e k;
    k = FK_OTHER;
    case (w.charisk)
      4'b0000:
        k = FK_DATA;
      4'b1111:
      begin
        if (w.data == {`KCH_CLKC, `KCH_CLKC, `KCH_CLKC, `KCH_CLKC})
          k = FK_CLKC;
      end
      4'b1100:
      begin
        if (w.data[31:24] == `KCH_COMMA && w.data[23:16] == `KCH_HANDSHAKE)
          k = FK_HANDSHAKE;
      end
      `IDLE_KBITS:
      begin
        if (w.data[31:24] == `KCH_IDLE)
          k = FK_IDLE;
      end
      default:
        k = FK_OTHER;
    endcase
    return k;
  endfunction

  task automatic abort_run();
    $display("Verification failed");
    $fatal(1, "Link testbench stopped on error");
  endtask

  task automatic check_word(input string name, input link_word_t exp, input link_word_t act);
    if (act !== exp)
    begin
      $display("FAIL t=%0t %s expected %h/%b actual %h/%b", $time, name,
               exp.data, exp.charisk, act.data, act.charisk);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("FAIL t=%0t %s expected %b actual %b", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_kind(input string name, input frame_kind_e exp, input frame_kind_e act);
    if (act !== exp)
    begin
      $display("FAIL t=%0t %s expected %s actual %s", $time, name, exp.name(), act.name());
      abort_run();
    end
  endtask

  // Random words with K-flags clear and at least one idle cycle between words
  task automatic send_burst(input int count);
    int   sent;
    int   gap;
    logic xfer_next;
    sent      = 0;
    gap       = 0;
    xfer_next = 1'b0;
    while (sent < count)
    begin
      @(negedge CLK_IN);
      // Word was taken at the rising edge just passed
      if (xfer_next)
      begin
        tx_vld    = 1'b0;
        sent      = sent + 1;
        rng_state = xorshift32(rng_state);
        gap       = 1 + int'(rng_state[1:0]);
      end
      if (gap > 0)
        gap = gap - 1;
      else if (!tx_vld && sent < count)
      begin
        rng_state = xorshift32(rng_state);
        tx_word   = make_word(rng_state, 4'b0000);
        tx_vld    = 1'b1;
      end
      // Ready is registered, so the coming edge is already known
      xfer_next = tx_vld && tx_rdy;
      if (xfer_next)
        exp_q.push_back(tx_word);
    end
  endtask

  task automatic wait_link_up();
    do
      @(negedge CLK_IN);
    while (!link_up);
  endtask

  task automatic wait_drain();
    do
      @(posedge CLK_IN);
    while (exp_q.size() != 0);
  endtask

  // Inputs seen by the DUT at each rising edge
  always @(posedge CLK_IN)
  begin
    rst_seen     <= RESET_IN;
    // Looped word is zero while corrupt or while link_tx still holds its reset value
    zero_src     <= corrupt || rst_seen;
    idle_sampled <= idle_value;
  end

  always @(posedge CLK_IN)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("Timeout after %0d cycles, the link test did not complete", cycle_cnt);
      abort_run();
    end
  end

  // Outputs are all registered and settled at the falling edge
  always @(negedge CLK_IN)
  begin
    if (rst_seen)
    begin
      check_bit("tx_rdy_o", 1'b0, tx_rdy);
      check_bit("rx_vld_o", 1'b0, rx_vld);
      check_bit("link_up_o", 1'b0, link_up);
      check_word("link_tx_o", ZERO_WORD, link_tx);
    end
    else
    begin
      mon_cycle = mon_cycle + 1;
      tx_kind   = ref_kind(link_tx);
      check_bit("link_tx_o framed", 1'b1, tx_kind != FK_OTHER);
      // Clock correction strictly periodic once the first one is seen
      if (last_clkc >= 0 && mon_cycle - last_clkc == `CLKC_INTERVAL + 1)
        check_kind("link_tx_o", FK_CLKC, tx_kind);
      else if (last_clkc >= 0)
        check_bit("link_tx_o early clkc", 1'b0, tx_kind == FK_CLKC);
      case (tx_kind)
        FK_CLKC:
        begin
          check_word("link_tx_o", make_word({4{`KCH_CLKC}}, 4'b1111), link_tx);
          check_bit("tx_rdy_o before clkc", 1'b0, prev_rdy);
          last_clkc  = mon_cycle;
          clkc_count = clkc_count + 1;
        end
        FK_HANDSHAKE:
        begin
          exp_word = make_word({`KCH_COMMA, `KCH_HANDSHAKE, 7'b0, link_tx.data[8],
                                `PROTOCOL_VERSION}, 4'b1100);
          check_word("link_tx_o", exp_word, link_tx);
          if (link_tx.data[8])
          begin
            check_bit("phase 0 handshake before phase 1", 1'b1, hs0_seen);
            hs1_seen = 1'b1;
          end
          else
          begin
            // Phase never falls back while the link stays down
            check_bit("phase 0 handshake after phase 1", 1'b0, hs1_seen);
            hs0_seen = 1'b1;
          end
        end
        FK_IDLE:
        begin
          if (idle_sampled != '0)
            exp_word = make_word({`KCH_IDLE, 8'h00, idle_sampled}, `IDLE_KBITS);
          else
          begin
            // LFSR steps once per pseudo-random idle frame sent
            exp_word   = make_word({`KCH_IDLE, 8'h00, lfsr_model}, `IDLE_KBITS);
            lfsr_model = lfsr_step(lfsr_model);
            lfsr_idles = lfsr_idles + 1;
          end
          check_word("link_tx_o", exp_word, link_tx);
        end
        default:
        begin
        end
      endcase
      // Both handshake phases go out before the link comes up
      if (link_up && !prev_up)
      begin
        check_bit("phase 0 handshake seen", 1'b1, hs0_seen);
        check_bit("phase 1 handshake seen", 1'b1, hs1_seen);
      end
      else if (!link_up && prev_up)
      begin
        hs0_seen = 1'b0;
        hs1_seen = 1'b0;
      end
      if (rx_vld)
      begin
        check_kind("rx_word_o kind", FK_DATA, ref_kind(rx_word));
        if (zero_src)
          check_word("rx_word_o", ZERO_WORD, rx_word);
        else if (exp_q.size() == 0)
        begin
          $display("Received data word %h at %0t with no user word outstanding",
                   rx_word.data, $time);
          abort_run();
        end
        else
        begin
          exp_word = exp_q.pop_front();
          check_word("rx_word_o", exp_word, rx_word);
        end
      end
      prev_rdy = tx_rdy;
      prev_up  = link_up;
    end
  end

  initial
  begin
    int held;
    RESET_IN   = 1'b1;
    corrupt    = 1'b0;
    tx_word    = ZERO_WORD;
    tx_vld     = 1'b0;
    rst_seen   = 1'b1;
    zero_src   = 1'b1;
    prev_rdy   = 1'b0;
    prev_up    = 1'b0;
    hs0_seen   = 1'b0;
    hs1_seen   = 1'b0;
    mon_cycle  = 0;
    last_clkc  = -1;
    clkc_count = 0;
    lfsr_idles = 0;
    cycle_cnt  = 0;
    lfsr_model = `LFSR_SEED;
    rng_state  = 32'h22d2b31f;
    rng_state  = xorshift32(rng_state);
    // Fixed nonzero idle value first
    idle_value = rng_state[15:0] | 16'h0001;
    repeat (3) @(posedge CLK_IN);
    @(negedge CLK_IN);
    RESET_IN = 1'b0;

    wait_link_up();
    send_burst(WORDS_PER_BURST);
    wait_drain();

    // Break the loopback until sync is lost and handshakes restart
    @(negedge CLK_IN);
    corrupt = 1'b1;
    held    = 0;
    do
    begin
      @(negedge CLK_IN);
      held = held + 1;
    end
    while (link_up);
    check_bit("link_up_o held past sync timeout", 1'b1, held > `SYNC_TIMEOUT);
    do
      @(posedge CLK_IN);
    while (!hs0_seen);
    @(negedge CLK_IN);
    corrupt    = 1'b0;
    idle_value = '0;

    wait_link_up();
    send_burst(WORDS_PER_BURST);
    wait_drain();
    // Watch idle and clock-correction frames for two more periods
    repeat (2 * (`CLKC_INTERVAL + 1)) @(posedge CLK_IN);

    check_bit("LFSR idle frames observed", 1'b1, lfsr_idles > 0);
    check_bit("clkc frames observed", 1'b1, clkc_count >= 2);
    $display("Verification passed");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+common
common/hss_link_pkg.sv
logic/hss_lfsr.sv
logic/hss_clkc_timer.sv
logic/hss_handshake_fsm.sv
hss_tx/hss_tx_control.sv
hss_rx/hss_rx_control.sv
logic/hss_link_top.sv
tests/hss_link_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the link testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=hss_link_sim

verilator --binary --timing -f verilog.f --top-module hss_link_tb -o "$SIM"
if [ $? -ne 0 ]; then
  echo "Verilator build returned an error"
  exit 1
fi

./obj_dir/"$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Verification passed" "$LOG"; then
  exit 0
fi
echo "Pass line not found in $LOG"
exit 1
